// ==== lsu_pkg.sv ====
package lsu_pkg;

    // ------------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------------
    localparam int unsigned XLEN          = 32;
    localparam int unsigned TRANS_ID_BITS = 3;
    localparam int unsigned BE_BITS       = 4;

    typedef enum logic [3:0] {
        LB  = 4'd0,
        LBU = 4'd1,
        LH  = 4'd2,
        LHU = 4'd3,
        LW  = 4'd4,
        SB  = 4'd5,
        SH  = 4'd6,
        SW  = 4'd7
    } lsu_op_e;

    localparam logic [3:0] CAUSE_LD_MISALIGNED = 4'd4;
    localparam logic [3:0] CAUSE_ST_MISALIGNED = 4'd6;

    typedef struct packed {
        logic            valid;
        logic [3:0]      cause;
        logic [XLEN-1:0] tval;
    } exception_t;

    // as delivered by the issue stage
    typedef struct packed {
        logic [XLEN-1:0]          operand_a;
        logic [XLEN-1:0]          imm;
        logic [XLEN-1:0]          operand_b;
        lsu_op_e                  op;
        logic [TRANS_ID_BITS-1:0] trans_id;
    } issue_req_t;

    typedef struct packed {
        logic                     valid;
        logic [XLEN-1:0]          vaddr;
        logic [XLEN-1:0]          wdata;
        logic [BE_BITS-1:0]       be;
        lsu_op_e                  op;
        logic                     is_load;
        logic                     misaligned;
        logic [TRANS_ID_BITS-1:0] trans_id;
    } lsu_ctrl_t;

    typedef struct packed {
        logic                     valid;
        logic [TRANS_ID_BITS-1:0] trans_id;
        logic [XLEN-1:0]          result;
        exception_t               ex;
    } lsu_result_t;

    typedef struct packed {
        logic               req;
        logic               we;
        logic [XLEN-1:0]    addr;
        logic [BE_BITS-1:0] sel;
        logic [XLEN-1:0]    wdata;
    } bus_req_t;

    typedef struct packed {
        logic            ack;
        logic [XLEN-1:0] rdata;
    } bus_rsp_t;

    // ------------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------------
    // size encoding: 0 byte, 1 halfword, 2 word
    function automatic logic [1:0] op_size(input lsu_op_e op);
        case (op)
            LB, LBU, SB: return 2'd0;
            LH, LHU, SH: return 2'd1;
            default:     return 2'd2;
        endcase
    endfunction

    function automatic logic op_is_load(input lsu_op_e op);
        return op inside {LB, LBU, LH, LHU, LW};
    endfunction

    function automatic logic [BE_BITS-1:0] be_gen(input logic [1:0] addr_lo,
                                                  input logic [1:0] size);
        case (size)
            2'd0:    return BE_BITS'(4'b0001 << addr_lo);
            2'd1:    return BE_BITS'(4'b0011 << addr_lo);
            default: return 4'b1111;
        endcase
    endfunction

endpackage

// ==== lsu_agu.sv ====
`timescale 1ns/1ps

module lsu_agu (
    input  lsu_pkg::issue_req_t req_i,
    input  logic                valid_i,
    output lsu_pkg::lsu_ctrl_t  ctrl_o
);

    logic [lsu_pkg::XLEN-1:0] vaddr;
    logic [1:0]               size;
    logic                     misaligned;

    // effective address, offset is a plain two's complement add
    assign vaddr = req_i.operand_a + req_i.imm;
    assign size  = lsu_pkg::op_size(req_i.op);

    // ------------------------------------------------------------------------
    // alignment check
    // ------------------------------------------------------------------------
    always_comb begin
        misaligned = 1'b0;
        case (size)
            2'd1:    misaligned = vaddr[0];
            2'd2:    misaligned = |vaddr[1:0];
            // bytes are always aligned
            default: misaligned = 1'b0;
        endcase
    end

    // ------------------------------------------------------------------------
    // packed request
    // ------------------------------------------------------------------------
    always_comb begin
        ctrl_o            = '0;
        ctrl_o.valid      = valid_i;
        ctrl_o.vaddr      = vaddr;
        // store data moved onto its byte lanes
        ctrl_o.wdata      = req_i.operand_b << {vaddr[1:0], 3'b000};
        ctrl_o.be         = lsu_pkg::be_gen(vaddr[1:0], size);
        ctrl_o.op         = req_i.op;
        ctrl_o.is_load    = lsu_pkg::op_is_load(req_i.op);
        ctrl_o.misaligned = misaligned;
        ctrl_o.trans_id   = req_i.trans_id;
    end

endmodule

// ==== lsu_bypass.sv ====
`timescale 1ns/1ps

module lsu_bypass (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  lsu_pkg::lsu_ctrl_t ctrl_i,
    input  logic               pop_ld_i,
    input  logic               pop_st_i,
    output lsu_pkg::lsu_ctrl_t ctrl_o,
    output logic               ready_o
);

    lsu_pkg::lsu_ctrl_t [1:0] mem_q;
    logic                     rd_ptr_q;
    logic                     wr_ptr_q;
    logic [1:0]               cnt_q;
    logic                     empty;
    logic                     push;
    logic                     pop;

    assign empty   = (cnt_q == 2'd0);
    assign ready_o = empty;

    // new requests only come in while nothing is pending
    assign push = ctrl_i.valid & empty;
    assign pop  = pop_ld_i | pop_st_i;

    // head is the incoming request while empty
    assign ctrl_o = empty ? ctrl_i : mem_q[rd_ptr_q];

    // ------------------------------------------------------------------------
    // pointers and fill level
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q <= 1'b0;
            wr_ptr_q <= 1'b0;
            cnt_q    <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr_q <= ~wr_ptr_q;
            end
            if (pop) begin
                rd_ptr_q <= ~rd_ptr_q;
            end
            cnt_q <= cnt_q + {1'b0, push} - {1'b0, pop};
        end
    end

    // entry storage
    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= ctrl_i;
        end
        // a pop in the same cycle as the push wins on the valid bit
        if (pop) begin
            mem_q[rd_ptr_q].valid <= 1'b0;
        end
    end

endmodule

// ==== load_unit.sv ====
`timescale 1ns/1ps

module load_unit (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  lsu_pkg::lsu_ctrl_t   ctrl_i,
    output logic                 pop_o,
    output lsu_pkg::bus_req_t    bus_o,
    input  lsu_pkg::bus_rsp_t    bus_i,
    output lsu_pkg::lsu_result_t result_o
);

    logic                              active;
    logic [lsu_pkg::XLEN-1:0]          shifted;
    logic [lsu_pkg::XLEN-1:0]          ext_data;
    logic                              valid_q;
    logic [lsu_pkg::TRANS_ID_BITS-1:0] trans_id_q;
    logic [lsu_pkg::XLEN-1:0]          data_q;
    lsu_pkg::exception_t               ex_q;

    assign active = ctrl_i.valid & ctrl_i.is_load;

    // read request straight from the head
    always_comb begin
        bus_o       = '0;
        bus_o.req   = active & ~ctrl_i.misaligned;
        bus_o.we    = 1'b0;
        bus_o.addr  = ctrl_i.vaddr;
        bus_o.sel   = ctrl_i.be;
    end

    // misaligned loads finish without touching the bus
    assign pop_o = active & (ctrl_i.misaligned | bus_i.ack);

    // ------------------------------------------------------------------------
    // data extraction and extension
    // ------------------------------------------------------------------------
    assign shifted = bus_i.rdata >> {ctrl_i.vaddr[1:0], 3'b000};

    always_comb begin
        case (ctrl_i.op)
            lsu_pkg::LB:  ext_data = {{24{shifted[7]}}, shifted[7:0]};
            lsu_pkg::LBU: ext_data = {24'b0, shifted[7:0]};
            lsu_pkg::LH:  ext_data = {{16{shifted[15]}}, shifted[15:0]};
            lsu_pkg::LHU: ext_data = {16'b0, shifted[15:0]};
            default:      ext_data = shifted;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= pop_o;
        end
    end

    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            trans_id_q <= ctrl_i.trans_id;
            data_q     <= ctrl_i.misaligned ? '0 : ext_data;
            ex_q.valid <= ctrl_i.misaligned;
            ex_q.cause <= lsu_pkg::CAUSE_LD_MISALIGNED;
            ex_q.tval  <= ctrl_i.vaddr;
        end
    end

    assign result_o = '{valid: valid_q, trans_id: trans_id_q, result: data_q, ex: ex_q};

endmodule

// ==== store_unit.sv ====
`timescale 1ns/1ps

module store_unit (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  lsu_pkg::lsu_ctrl_t   ctrl_i,
    output logic                 pop_o,
    output lsu_pkg::bus_req_t    bus_o,
    input  lsu_pkg::bus_rsp_t    bus_i,
    output lsu_pkg::lsu_result_t result_o
);

    logic                              active;
    logic                              valid_q;
    logic [lsu_pkg::TRANS_ID_BITS-1:0] trans_id_q;
    lsu_pkg::exception_t               ex_q;

    assign active = ctrl_i.valid & ~ctrl_i.is_load;

    // write with data already on its lanes from address generation
    always_comb begin
        bus_o       = '0;
        bus_o.req   = active & ~ctrl_i.misaligned;
        bus_o.we    = 1'b1;
        bus_o.addr  = ctrl_i.vaddr;
        bus_o.sel   = ctrl_i.be;
        bus_o.wdata = ctrl_i.wdata;
    end

    assign pop_o = active & (ctrl_i.misaligned | bus_i.ack);

    // ------------------------------------------------------------------------
    // result register
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= pop_o;
        end
    end

    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            trans_id_q <= ctrl_i.trans_id;
            ex_q.valid <= ctrl_i.misaligned;
            ex_q.cause <= lsu_pkg::CAUSE_ST_MISALIGNED;
            ex_q.tval  <= ctrl_i.vaddr;
        end
    end

    // stores write back nothing
    assign result_o = '{valid: valid_q, trans_id: trans_id_q, result: '0, ex: ex_q};

endmodule

// ==== lsu_bus_arbiter.sv ====
`timescale 1ns/1ps

module lsu_bus_arbiter (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    input  lsu_pkg::bus_req_t            ld_req_i,
    input  lsu_pkg::bus_req_t            st_req_i,
    output lsu_pkg::bus_rsp_t            ld_rsp_o,
    output lsu_pkg::bus_rsp_t            st_rsp_o,
    output logic                         wb_cyc_o,
    output logic                         wb_stb_o,
    output logic                         wb_we_o,
    output logic [lsu_pkg::XLEN-1:0]     wb_adr_o,
    output logic [lsu_pkg::BE_BITS-1:0]  wb_sel_o,
    output logic [lsu_pkg::XLEN-1:0]     wb_dat_o,
    input  logic [lsu_pkg::XLEN-1:0]     wb_dat_i,
    input  logic                         wb_ack_i
);

    logic              busy_q;
    logic              gnt_ld_q;
    logic              gnt_ld;
    lsu_pkg::bus_req_t sel_req;

    // grant frozen while a cycle is open, load first otherwise
    assign gnt_ld  = busy_q ? gnt_ld_q : ld_req_i.req;
    assign sel_req = gnt_ld ? ld_req_i : st_req_i;

    // ------------------------------------------------------------------------
    // wishbone classic master
    // ------------------------------------------------------------------------
    assign wb_cyc_o = sel_req.req;
    assign wb_stb_o = sel_req.req;
    assign wb_we_o  = sel_req.we;
    assign wb_adr_o = {sel_req.addr[lsu_pkg::XLEN-1:2], 2'b00};
    assign wb_sel_o = sel_req.sel;
    assign wb_dat_o = sel_req.wdata;

    assign ld_rsp_o = '{ack: wb_ack_i & gnt_ld, rdata: gnt_ld ? wb_dat_i : '0};
    assign st_rsp_o = '{ack: wb_ack_i & ~gnt_ld, rdata: gnt_ld ? '0 : wb_dat_i};

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            busy_q   <= 1'b0;
            gnt_ld_q <= 1'b0;
        end else begin
            busy_q   <= wb_cyc_o & ~wb_ack_i;
            gnt_ld_q <= gnt_ld;
        end
    end

endmodule

// ==== load_store_unit.sv ====
`timescale 1ns/1ps

module load_store_unit (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    input  logic                         lsu_valid_i,
    input  lsu_pkg::issue_req_t          issue_i,
    output logic                         lsu_ready_o,
    output lsu_pkg::lsu_result_t         load_result_o,
    output lsu_pkg::lsu_result_t         store_result_o,
    output logic                         wb_cyc_o,
    output logic                         wb_stb_o,
    output logic                         wb_we_o,
    output logic [lsu_pkg::XLEN-1:0]     wb_adr_o,
    output logic [lsu_pkg::BE_BITS-1:0]  wb_sel_o,
    output logic [lsu_pkg::XLEN-1:0]     wb_dat_o,
    input  logic [lsu_pkg::XLEN-1:0]     wb_dat_i,
    input  logic                         wb_ack_i
);

    lsu_pkg::lsu_ctrl_t agu_ctrl;
    lsu_pkg::lsu_ctrl_t head_ctrl;
    logic               pop_ld;
    logic               pop_st;
    lsu_pkg::bus_req_t  ld_bus_req;
    lsu_pkg::bus_req_t  st_bus_req;
    lsu_pkg::bus_rsp_t  ld_bus_rsp;
    lsu_pkg::bus_rsp_t  st_bus_rsp;

    lsu_agu lsu_agu_i (
        .req_i   (issue_i),
        .valid_i (lsu_valid_i),
        .ctrl_o  (agu_ctrl)
    );

    // ------------------------------------------------------------------------
    // request buffer feeding both units
    // ------------------------------------------------------------------------
    lsu_bypass lsu_bypass_i (
        .clk_i,
        .rst_ni,
        .ctrl_i   (agu_ctrl),
        .pop_ld_i (pop_ld),
        .pop_st_i (pop_st),
        .ctrl_o   (head_ctrl),
        .ready_o  (lsu_ready_o)
    );

    load_unit load_unit_i (
        .clk_i,
        .rst_ni,
        .ctrl_i   (head_ctrl),
        .pop_o    (pop_ld),
        .bus_o    (ld_bus_req),
        .bus_i    (ld_bus_rsp),
        .result_o (load_result_o)
    );

    store_unit store_unit_i (
        .clk_i,
        .rst_ni,
        .ctrl_i   (head_ctrl),
        .pop_o    (pop_st),
        .bus_o    (st_bus_req),
        .bus_i    (st_bus_rsp),
        .result_o (store_result_o)
    );

    lsu_bus_arbiter lsu_bus_arbiter_i (
        .clk_i,
        .rst_ni,
        .ld_req_i (ld_bus_req),
        .st_req_i (st_bus_req),
        .ld_rsp_o (ld_bus_rsp),
        .st_rsp_o (st_bus_rsp),
        .wb_cyc_o,
        .wb_stb_o,
        .wb_we_o,
        .wb_adr_o,
        .wb_sel_o,
        .wb_dat_o,
        .wb_dat_i,
        .wb_ack_i
    );

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int unsigned PERIOD_NS    = 100,
    parameter int unsigned RESET_CYCLES = 3
) (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_o = ~clk_o;
        end
    end

    // reset held low for a fixed number of rising edges
    initial begin
        rst_no = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_no <= 1'b1;
    end

endmodule

// ==== tb_load_store_unit.sv ====
`timescale 1ns/1ps

module tb_load_store_unit;

    localparam int unsigned NUM_REQ   = 400;
    localparam int unsigned MEM_WORDS = 256;
    localparam int unsigned TIMEOUT   = 40;
    localparam logic [15:0] SEED      = 16'd93;

    typedef struct packed {
        logic        is_load;
        logic [2:0]  trans_id;
        logic [31:0] result;
        logic        ex_valid;
        logic [3:0]  cause;
        logic [31:0] tval;
        logic [31:0] accept_cycle;
    } exp_result_t;

    typedef struct packed {
        logic        we;
        logic [31:0] adr;
        logic [3:0]  sel;
        logic [31:0] dat;
    } exp_bus_t;

    logic                 clk_i;
    logic                 rst_ni;
    logic                 lsu_valid_i;
    lsu_pkg::issue_req_t  issue_i;
    logic                 lsu_ready_o;
    lsu_pkg::lsu_result_t load_result_o;
    lsu_pkg::lsu_result_t store_result_o;
    logic                 wb_cyc_o;
    logic                 wb_stb_o;
    logic                 wb_we_o;
    logic [31:0]          wb_adr_o;
    logic [3:0]           wb_sel_o;
    logic [31:0]          wb_dat_o;
    logic [31:0]          wb_dat_i;
    logic                 wb_ack_i;

    logic [31:0]          wb_mem [MEM_WORDS];
    logic [31:0]          ref_mem [MEM_WORDS];
    exp_result_t          exp_res_q [$];
    exp_bus_t             exp_bus_q [$];
    logic [15:0]          stim_lfsr;
    logic [15:0]          ack_lfsr;
    int unsigned          cycle_cnt;
    int unsigned          n_results;
    // wishbone slave state
    logic                 bus_busy;
    int unsigned          ack_wait;
    exp_bus_t             cur_bus;
    exp_bus_t             bus_seen;
    logic [31:0]          ack_draw;
    lsu_pkg::lsu_result_t got_res;
    exp_result_t          exp_res;
    // ack as seen one edge earlier
    logic                 ack_last;

    tb_clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(3)) tb_clock_gen_i (
        .clk_o  (clk_i),
        .rst_no (rst_ni)
    );

    load_store_unit load_store_unit_i (
        .clk_i, .rst_ni, .lsu_valid_i, .issue_i, .lsu_ready_o,
        .load_result_o, .store_result_o,
        .wb_cyc_o, .wb_stb_o, .wb_we_o, .wb_adr_o, .wb_sel_o, .wb_dat_o,
        .wb_dat_i, .wb_ack_i
    );

    // ------------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------------
    task automatic report_error(input bit wrong_value, input string msg);
        if (wrong_value) begin
            $display("FAILED at %0t ns: %s", $time, msg);
        end else begin
            $display("%s (at %0t ns)", msg, $time);
        end
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at first error");
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw(inout logic [15:0] s, input int unsigned n, output logic [31:0] v);
        v = '0;
        for (int unsigned k = 0; k < n; k++) begin
            s = lfsr_step(s);
            v = {v[30:0], s[0]};
        end
    endtask

    function automatic logic [31:0] fill_word(input logic [7:0] idx);
        return {~idx, idx ^ 8'h3c, idx + 8'h5a, idx * 8'd7};
    endfunction

    function automatic int unsigned op_bytes(input lsu_pkg::lsu_op_e op);
        case (op)
            lsu_pkg::LB, lsu_pkg::LBU, lsu_pkg::SB: return 1;
            lsu_pkg::LH, lsu_pkg::LHU, lsu_pkg::SH: return 2;
            default:                                return 4;
        endcase
    endfunction

    function automatic logic [31:0] load_value(input lsu_pkg::lsu_op_e op,
                                               input logic [31:0] word,
                                               input logic [1:0] lo);
        logic [31:0] sh;
        logic [7:0]  b;
        logic [15:0] h;
        sh = word >> (8 * lo);
        b  = sh[7:0];
        h  = sh[15:0];
        case (op)
            lsu_pkg::LB:  return 32'($signed(b));
            lsu_pkg::LBU: return 32'(b);
            lsu_pkg::LH:  return 32'($signed(h));
            lsu_pkg::LHU: return 32'(h);
            default:      return word;
        endcase
    endfunction

    function automatic logic lanes_match(input logic [3:0] sel, input logic [31:0] a,
                                         input logic [31:0] b);
        logic ok;
        ok = 1'b1;
        for (int k = 0; k < 4; k++) begin
            if (sel[k] && a[8*k +: 8] !== b[8*k +: 8]) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // ------------------------------------------------------------------------
    // wishbone memory slave with random ack delay
    // ------------------------------------------------------------------------
    always @(posedge clk_i) begin
        if (!rst_ni) begin
            wb_ack_i <= 1'b0;
            bus_busy  = 1'b0;
        end else if (wb_ack_i) begin
            wb_ack_i <= 1'b0;
            bus_busy  = 1'b0;
        end else if (bus_busy || wb_cyc_o) begin
            if (!bus_busy) begin
                assert (exp_bus_q.size() != 0)
                    else report_error(1'b0, "bus cycle started for a request that needs none");
                cur_bus = exp_bus_q.pop_front();
                assert (wb_stb_o && wb_we_o == cur_bus.we && wb_adr_o == cur_bus.adr &&
                        wb_sel_o == cur_bus.sel)
                    else report_error(1'b1, $sformatf("bus we=%b adr=%h sel=%b, expected %b %h %b",
                        wb_we_o, wb_adr_o, wb_sel_o, cur_bus.we, cur_bus.adr, cur_bus.sel));
                assert (!cur_bus.we || lanes_match(wb_sel_o, wb_dat_o, cur_bus.dat))
                    else report_error(1'b1, $sformatf("write data %h, expected %h on sel %b",
                        wb_dat_o, cur_bus.dat, wb_sel_o));
                bus_seen = {wb_we_o, wb_adr_o, wb_sel_o, wb_dat_o};
                draw(ack_lfsr, 2, ack_draw);
                ack_wait = ack_draw[1:0];
                bus_busy = 1'b1;
            end else begin
                assert (wb_cyc_o && wb_stb_o && {wb_we_o, wb_adr_o, wb_sel_o, wb_dat_o} == bus_seen)
                    else report_error(1'b0, "wishbone signals changed before ack");
            end
            if (ack_wait == 0) begin
                if (wb_we_o) begin
                    for (int k = 0; k < 4; k++) begin
                        if (wb_sel_o[k]) begin
                            wb_mem[wb_adr_o[9:2]][8*k +: 8] = wb_dat_o[8*k +: 8];
                        end
                    end
                end else begin
                    wb_dat_i <= wb_mem[wb_adr_o[9:2]];
                end
                wb_ack_i <= 1'b1;
            end else begin
                ack_wait--;
            end
        end
    end

    // ------------------------------------------------------------------------
    // result monitor, in issue order
    // ------------------------------------------------------------------------
    always @(posedge clk_i) begin
        if (rst_ni) begin
            assert (!(load_result_o.valid && store_result_o.valid))
                else report_error(1'b0, "load and store results valid in the same cycle");
            if (load_result_o.valid || store_result_o.valid) begin
                got_res = load_result_o.valid ? load_result_o : store_result_o;
                assert (exp_res_q.size() != 0)
                    else report_error(1'b0, "result seen with no request outstanding");
                exp_res = exp_res_q.pop_front();
                assert (load_result_o.valid == exp_res.is_load)
                    else report_error(1'b1, "result came from the wrong unit");
                assert (got_res.trans_id == exp_res.trans_id && got_res.result == exp_res.result)
                    else report_error(1'b1, $sformatf("id %0d data %h, expected id %0d data %h",
                        got_res.trans_id, got_res.result, exp_res.trans_id, exp_res.result));
                assert (got_res.ex.valid == exp_res.ex_valid)
                    else report_error(1'b1, $sformatf("exception valid %b, expected %b",
                        got_res.ex.valid, exp_res.ex_valid));
                if (exp_res.ex_valid) begin
                    assert (got_res.ex.cause == exp_res.cause && got_res.ex.tval == exp_res.tval)
                        else report_error(1'b1, $sformatf("cause %0d tval %h, expected %0d %h",
                            got_res.ex.cause, got_res.ex.tval, exp_res.cause, exp_res.tval));
                    // misaligned result one cycle after the request is head
                    assert (cycle_cnt == exp_res.accept_cycle + 1)
                        else report_error(1'b1, "misaligned result arrived late");
                end else begin
                    // aligned result one cycle after the ack
                    assert (ack_last)
                        else report_error(1'b1, "result not one cycle after ack");
                end
                n_results++;
            end
        end
        ack_last = wb_ack_i;
    end

    // ------------------------------------------------------------------------
    // stimulus and reference model
    // ------------------------------------------------------------------------
    initial begin
        lsu_pkg::issue_req_t req;
        exp_result_t         er;
        exp_bus_t            eb;
        logic [31:0]         rnd;
        logic [31:0]         addr;
        logic [31:0]         imm;
        logic [9:0]          last_store;
        logic [3:0]          mask;
        logic                is_load;
        int unsigned         nbytes;
        int unsigned         waited;

        lsu_valid_i = 1'b0;
        issue_i     = '0;
        wb_ack_i    = 1'b0;
        wb_dat_i    = '0;
        stim_lfsr   = SEED;
        ack_lfsr    = SEED;
        cycle_cnt   = 0;
        n_results   = 0;
        last_store  = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            wb_mem[i]  = fill_word(8'(i));
            ref_mem[i] = fill_word(8'(i));
        end

        waited = 0;
        while (rst_ni !== 1'b1) begin
            @(posedge clk_i);
            waited++;
            assert (waited < TIMEOUT) else report_error(1'b0, "reset was never released");
        end
        @(posedge clk_i);
        assert (lsu_ready_o && !load_result_o.valid && !store_result_o.valid &&
                !wb_cyc_o && !wb_stb_o)
            else report_error(1'b1, "outputs not idle after reset");

        for (int unsigned i = 0; i < NUM_REQ; i++) begin
            draw(stim_lfsr, 3, rnd);
            req.op = lsu_pkg::lsu_op_e'({1'b0, rnd[2:0]});
            draw(stim_lfsr, 3, rnd);
            req.trans_id = rnd[2:0];
            draw(stim_lfsr, 32, rnd);
            req.operand_b = rnd;
            draw(stim_lfsr, 12, rnd);
            imm = {{20{rnd[11]}}, rnd[11:0]};
            draw(stim_lfsr, 12, rnd);
            addr = {22'b0, rnd[9:0]};
            // revisit the last stored word now and then
            if (rnd[11:10] == 2'b00) begin
                addr[9:2] = last_store[9:2];
            end
            req.imm       = imm;
            req.operand_a = addr - imm;

            is_load = req.op inside {lsu_pkg::LB, lsu_pkg::LBU, lsu_pkg::LH,
                                     lsu_pkg::LHU, lsu_pkg::LW};
            nbytes  = op_bytes(req.op);
            er          = '0;
            er.is_load  = is_load;
            er.trans_id = req.trans_id;
            if ((int'(addr[1:0]) % nbytes) != 0) begin
                er.ex_valid = 1'b1;
                er.cause    = is_load ? 4'd4 : 4'd6;
                er.tval     = addr;
            end else begin
                mask   = 4'((1 << nbytes) - 1);
                mask   = mask << addr[1:0];
                eb.we  = !is_load;
                eb.adr = {addr[31:2], 2'b00};
                eb.sel = mask;
                eb.dat = '0;
                if (is_load) begin
                    er.result = load_value(req.op, ref_mem[addr[9:2]], addr[1:0]);
                end else begin
                    for (int unsigned k = 0; k < nbytes; k++) begin
                        eb.dat[8*(addr[1:0]+k) +: 8]              = req.operand_b[8*k +: 8];
                        ref_mem[addr[9:2]][8*(addr[1:0]+k) +: 8] = req.operand_b[8*k +: 8];
                    end
                    last_store = addr[9:0];
                end
                exp_bus_q.push_back(eb);
            end

            lsu_valid_i <= 1'b1;
            issue_i     <= req;
            waited = 0;
            do begin
                @(posedge clk_i);
                waited++;
                assert (waited < TIMEOUT) else report_error(1'b0, "request was never accepted");
            end while (!lsu_ready_o);
            er.accept_cycle = cycle_cnt;
            exp_res_q.push_back(er);

            // occasional idle gap, otherwise back-to-back
            draw(stim_lfsr, 4, rnd);
            if (rnd[1:0] == 2'b00) begin
                lsu_valid_i <= 1'b0;
                repeat (rnd[3:2] + 1) @(posedge clk_i);
            end
        end
        lsu_valid_i <= 1'b0;

        waited = 0;
        while (exp_res_q.size() != 0) begin
            @(posedge clk_i);
            waited++;
            assert (waited < TIMEOUT) else report_error(1'b0, "results still missing at end of run");
        end
        assert (exp_bus_q.size() == 0) else report_error(1'b0, "expected bus cycles never happened");
        for (int i = 0; i < MEM_WORDS; i++) begin
            assert (wb_mem[i] == ref_mem[i])
                else report_error(1'b1, $sformatf("memory word %0d is %h, expected %h",
                    i, wb_mem[i], ref_mem[i]));
        end

        $display("%0d results checked", n_results);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// ==== load_store_unit.f ====
lsu_pkg.sv
lsu_agu.sv
lsu_bypass.sv
load_unit.sv
store_unit.sv
lsu_bus_arbiter.sv
load_store_unit.sv
tb_clock_gen.sv
tb_load_store_unit.sv

// ==== Bender.yml ====
package:
  name: load_store_unit

sources:
  - lsu_pkg.sv
  - lsu_agu.sv
  - lsu_bypass.sv
  - load_unit.sv
  - store_unit.sv
  - lsu_bus_arbiter.sv
  - load_store_unit.sv
  - target: simulation
    files:
      - tb_clock_gen.sv
      - tb_load_store_unit.sv
